// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// register index, 16 registers
`define CORE_ADDR_SIZE 4

// register width
`define CORE_DATA_SIZE 8

// host instruction word
`define CORE_INSTR_SIZE 16

`define CORE_OP_SIZE 4

`endif

// ==== source/core_isa_pkg.sv ====
`default_nettype none

`include "core_consts.svh"

package core_isa_pkg;

   // codes 8 to 15 are unused and run as NOP
   typedef enum logic [`CORE_OP_SIZE-1:0] {
      NOP  = 4'h0,
      LDI  = 4'h1,
      ADD  = 4'h2,
      SUB  = 4'h3,
      XOR  = 4'h4,
      AND  = 4'h5,
      OUT  = 4'h6, // reports rs0
      WAIT = 4'h7
   } opcode_t;

   typedef struct packed {
      opcode_t                    op;
      logic [`CORE_ADDR_SIZE-1:0] rd;
      logic [`CORE_ADDR_SIZE-1:0] rs0;
      logic [`CORE_ADDR_SIZE-1:0] rs1;
   } regForm_t;

   typedef struct packed {
      opcode_t                    op;
      logic [`CORE_ADDR_SIZE-1:0] rd;
      logic [`CORE_DATA_SIZE-1:0] imm; // cycle count for WAIT
   } immForm_t;

   typedef union packed {
      regForm_t asReg;
      immForm_t asImm;
   } instrWord_t;

endpackage

`default_nettype wire

// ==== source/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

   typedef enum logic [2:0] {
      IDLE,
      READ,     // operands presented to the register file
      EXEC,     // ALU writeback or OUT result
      WRITEIMM,
      STALL     // WAIT and NOP, held until the timer expires
   } seqState_t;

   typedef enum logic [1:0] {
      ADD,
      SUB,
      XOR,
      AND
   } aluOp_t;

endpackage

`default_nettype wire

// ==== source/ramDualPort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module ramDualPort #(
   parameter int AddrSize = `CORE_ADDR_SIZE,
   parameter int DataSize = `CORE_DATA_SIZE
) (
   input  wire                 clock,
   input  wire                 reset,
   input  wire                 we_i,
   input  wire  [AddrSize-1:0] addr0_i,
   input  wire  [AddrSize-1:0] addr1_i,
   input  wire  [DataSize-1:0] data_i,
   output logic [DataSize-1:0] data0_o,
   output logic [DataSize-1:0] data1_o
);

   logic [DataSize-1:0] mem [2**AddrSize];

   initial begin
      for (int k = 0; k < 2**AddrSize; k++) begin
         mem[k] = '0;
      end
   end

   always @(posedge clock) begin
      if (reset) begin
         data0_o <= '0; // outputs only, contents survive
         data1_o <= '0;
      end else begin
         if (we_i) begin
            mem[addr0_i] <= data_i;
         end
         data0_o <= mem[addr0_i]; // old value on a write
         data1_o <= mem[addr1_i];
      end
   end

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module aluUnit (
   input  wire core_ctrl_pkg::aluOp_t      op_i,
   input  wire [`CORE_DATA_SIZE-1:0]       a_i,
   input  wire [`CORE_DATA_SIZE-1:0]       b_i,
   output logic [`CORE_DATA_SIZE-1:0]      result_o
);

   // results wrap at the register width
   always_comb begin
      case (op_i)
         core_ctrl_pkg::ADD: begin
            result_o = a_i + b_i;
         end
         core_ctrl_pkg::SUB: begin
            result_o = a_i - b_i;
         end
         core_ctrl_pkg::XOR: begin
            result_o = a_i ^ b_i;
         end
         core_ctrl_pkg::AND: begin
            result_o = a_i & b_i;
         end
         default: begin
            result_o = a_i + b_i;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== source/delayTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module delayTimer (
   input  wire                        clock,
   input  wire                        reset,
   input  wire                        load_i,
   input  wire [`CORE_DATA_SIZE-1:0]  count_i,
   output logic                       expired_o
);

   logic [`CORE_DATA_SIZE-1:0] count;
   logic                       active;

   always_ff @(posedge clock) begin
      if (reset) begin
         active <= 1'b0;
         count  <= '0;
      end else if (load_i) begin
         active <= 1'b1;
         count  <= count_i;
      end else if (active) begin
         if (count == '0) begin
            active <= 1'b0; // expiry lasts one cycle
         end else begin
            count <= count - 1'b1;
         end
      end
   end

   // high in the cycle right after a load of zero
   assign expired_o = active && (count == '0);

endmodule

`default_nettype wire

// ==== source/instrSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module instrSequencer (
   input  wire                              clock,
   input  wire                              reset,
   input  wire                              instrValid_i,
   input  wire core_isa_pkg::instrWord_t    instr_i,
   input  wire                              expired_i,
   input  wire [`CORE_DATA_SIZE-1:0]        aluResult_i,
   output logic                             busy_o,
   output logic                             ramWe_o,
   output logic [`CORE_ADDR_SIZE-1:0]       ramAddr0_o,
   output logic [`CORE_ADDR_SIZE-1:0]       ramAddr1_o,
   output logic [`CORE_DATA_SIZE-1:0]       ramWrData_o,
   output core_ctrl_pkg::aluOp_t            aluOp_o,
   output logic                             timerLoad_o,
   output logic [`CORE_DATA_SIZE-1:0]       timerCount_o,
   output logic                             resultValid_o
);

   core_ctrl_pkg::seqState_t state;
   core_isa_pkg::instrWord_t instrReg;
   core_isa_pkg::opcode_t    newOp;
   core_isa_pkg::opcode_t    curOp;
   logic                     accept;
   logic                     newIsRead;
   logic                     isAluOp;

   assign accept = (state == core_ctrl_pkg::IDLE) && instrValid_i;
   assign newOp  = instr_i.asReg.op;
   assign curOp  = instrReg.asReg.op;

   assign newIsRead = newOp inside {core_isa_pkg::ADD, core_isa_pkg::SUB,
                                    core_isa_pkg::XOR, core_isa_pkg::AND,
                                    core_isa_pkg::OUT};
   assign isAluOp   = curOp inside {core_isa_pkg::ADD, core_isa_pkg::SUB,
                                    core_isa_pkg::XOR, core_isa_pkg::AND};

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= core_ctrl_pkg::IDLE;
      end else begin
         case (state)
            core_ctrl_pkg::IDLE: begin
               if (instrValid_i) begin
                  if (newIsRead) begin
                     state <= core_ctrl_pkg::READ;
                  end else if (newOp == core_isa_pkg::LDI) begin
                     state <= core_ctrl_pkg::WRITEIMM;
                  end else begin
                     state <= core_ctrl_pkg::STALL; // WAIT, NOP, unknown
                  end
               end
            end
            core_ctrl_pkg::READ:     state <= core_ctrl_pkg::EXEC;
            core_ctrl_pkg::EXEC:     state <= core_ctrl_pkg::IDLE;
            core_ctrl_pkg::WRITEIMM: state <= core_ctrl_pkg::IDLE;
            core_ctrl_pkg::STALL: begin
               if (expired_i) begin
                  state <= core_ctrl_pkg::IDLE;
               end
            end
            default:                 state <= core_ctrl_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (accept) begin
         instrReg <= instr_i;
      end
   end

   // NOP stalls on a zero count, one cycle
   assign timerLoad_o  = accept && !newIsRead && (newOp != core_isa_pkg::LDI);
   assign timerCount_o = (newOp == core_isa_pkg::WAIT) ? instr_i.asImm.imm : '0;

   always_comb begin
      ramAddr0_o = instrReg.asReg.rd; // rd sits at the same bits in both forms
      ramAddr1_o = instrReg.asReg.rs1;
      if (state == core_ctrl_pkg::READ) begin
         ramAddr0_o = instrReg.asReg.rs0;
      end
   end

   always_comb begin
      case (curOp)
         core_isa_pkg::SUB: aluOp_o = core_ctrl_pkg::SUB;
         core_isa_pkg::XOR: aluOp_o = core_ctrl_pkg::XOR;
         core_isa_pkg::AND: aluOp_o = core_ctrl_pkg::AND;
         default:           aluOp_o = core_ctrl_pkg::ADD;
      endcase
   end

   assign ramWe_o = ((state == core_ctrl_pkg::EXEC) && isAluOp) ||
                    (state == core_ctrl_pkg::WRITEIMM);
   assign ramWrData_o = (state == core_ctrl_pkg::WRITEIMM) ? instrReg.asImm.imm
                                                           : aluResult_i;

   assign resultValid_o = (state == core_ctrl_pkg::EXEC) && (curOp == core_isa_pkg::OUT);
   assign busy_o        = (state != core_ctrl_pkg::IDLE);

endmodule

`default_nettype wire

// ==== source/microCoreTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module microCoreTop (
   input  wire                              clock,
   input  wire                              reset,
   input  wire                              instrValid_i,
   input  wire [`CORE_INSTR_SIZE-1:0]       instr_i,
   output logic                             busy_o,
   output logic                             resultValid_o,
   output logic [`CORE_DATA_SIZE-1:0]       resultData_o
);

   logic                         ramWe;
   logic [`CORE_ADDR_SIZE-1:0]   ramAddr0;
   logic [`CORE_ADDR_SIZE-1:0]   ramAddr1;
   logic [`CORE_DATA_SIZE-1:0]   ramWrData;
   logic [`CORE_DATA_SIZE-1:0]   ramData0;
   logic [`CORE_DATA_SIZE-1:0]   ramData1;
   logic [`CORE_DATA_SIZE-1:0]   aluResult;
   core_ctrl_pkg::aluOp_t        aluOp;
   logic                         timerLoad;
   logic [`CORE_DATA_SIZE-1:0]   timerCount;
   logic                         timerExpired;

   instrSequencer instrSequencer_inst (
      .clock         (clock),
      .reset         (reset),
      .instrValid_i  (instrValid_i),
      .instr_i       (core_isa_pkg::instrWord_t'(instr_i)),
      .expired_i     (timerExpired),
      .aluResult_i   (aluResult),
      .busy_o        (busy_o),
      .ramWe_o       (ramWe),
      .ramAddr0_o    (ramAddr0),
      .ramAddr1_o    (ramAddr1),
      .ramWrData_o   (ramWrData),
      .aluOp_o       (aluOp),
      .timerLoad_o   (timerLoad),
      .timerCount_o  (timerCount),
      .resultValid_o (resultValid_o)
   );

   ramDualPort #(
      .AddrSize (`CORE_ADDR_SIZE),
      .DataSize (`CORE_DATA_SIZE)
   ) ramDualPort_inst (
      .clock   (clock),
      .reset   (reset),
      .we_i    (ramWe),
      .addr0_i (ramAddr0),
      .addr1_i (ramAddr1),
      .data_i  (ramWrData),
      .data0_o (ramData0),
      .data1_o (ramData1)
   );

   aluUnit aluUnit_inst (
      .op_i     (aluOp),
      .a_i      (ramData0),
      .b_i      (ramData1),
      .result_o (aluResult)
   );

   delayTimer delayTimer_inst (
      .clock     (clock),
      .reset     (reset),
      .load_i    (timerLoad),
      .count_i   (timerCount),
      .expired_o (timerExpired)
   );

   assign resultData_o = ramData0; // port 0 holds rs0 during OUT

endmodule

`default_nettype wire

// ==== tests/microCoreTop_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module microCoreTop_props (
   input wire                            clock,
   input wire                            reset,
   input wire core_ctrl_pkg::seqState_t  state_i,
   input wire                            ramWe_i,
   input wire                            resultValid_i,
   input wire                            busy_i
);

   singleResultPulse: assert property (@(posedge clock) disable iff (reset)
      resultValid_i |=> !resultValid_i)
      else $error("result pulse held high for two cycles");

   noWriteInIdle: assert property (@(posedge clock) disable iff (reset)
      (state_i == core_ctrl_pkg::IDLE) |-> !ramWe_i)
      else $error("register file written while the sequencer is idle");

   idleAfterReset: assert property (@(posedge clock) reset |=> !busy_i)
      else $error("busy high in the cycle after reset");

endmodule

bind instrSequencer microCoreTop_props microCoreTop_props_inst (
   .clock         (clock),
   .reset         (reset),
   .state_i       (state),
   .ramWe_i       (ramWe_o),
   .resultValid_i (resultValid_o),
   .busy_i        (busy_o)
);

`default_nettype wire

// ==== tests/microCoreTop_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module microCoreTop_checker (
   input  wire                         clock,
   input  wire                         reset,
   input  wire                         instrValid_i,
   input  wire [`CORE_INSTR_SIZE-1:0]  instr_i,
   input  wire                         busy_i,
   input  wire                         resultValid_i,
   input  wire [`CORE_DATA_SIZE-1:0]   resultData_i,
   input  wire [3:0]                   testId_i,
   output int                          errorCount_o,
   output int                          checkCount_o
);

   logic [`CORE_DATA_SIZE-1:0] mirror [2**`CORE_ADDR_SIZE];
   logic [`CORE_DATA_SIZE-1:0] expOut;
   int                         expBusy;
   int                         busyCount;
   int                         errors = 0;
   int                         checks = 0;
   bit                         expectOut = 1'b0;
   bit                         outSeen = 1'b0;
   bit                         measuring = 1'b0;
   bit                         wasReset = 1'b0;

   assign errorCount_o = errors;
   assign checkCount_o = checks;

   initial begin
      for (int k = 0; k < 2**`CORE_ADDR_SIZE; k++) begin
         mirror[k] = '0;
      end
   end

   function automatic string testLabel(input logic [3:0] id);
      case (id)
         4'd1:    return "resetOuts";
         4'd2:    return "ldiOut";
         4'd3:    return "aluMix";
         4'd4:    return "waitCycles";
         4'd5:    return "busyStrobe";
         4'd6:    return "unknownOp";
         default: return "reset";
      endcase
   endfunction

   task automatic checkValue(input string what, input int expected, input int actual);
      checks++;
      if (expected != actual) begin
         errors++;
         $display("Mismatch %s %s: expected %0d, actual %0d",
                  testLabel(testId_i), what, expected, actual);
      end
   endtask

   task automatic reportError(input string what);
      errors++;
      $display("ERROR %s: %s", testLabel(testId_i), what);
   endtask

   // applies one accepted instruction to the mirror
   function automatic void predict(input core_isa_pkg::instrWord_t word, output int busyLen,
                                   output logic [`CORE_DATA_SIZE-1:0] outVal,
                                   output bit isOut);
      core_isa_pkg::regForm_t r;
      core_isa_pkg::immForm_t m;
      r       = word.asReg;
      m       = word.asImm;
      busyLen = 1;
      outVal  = '0;
      isOut   = 1'b0;
      case (r.op)
         core_isa_pkg::LDI:  mirror[m.rd] = m.imm;
         core_isa_pkg::ADD:  mirror[r.rd] = mirror[r.rs0] + mirror[r.rs1];
         core_isa_pkg::SUB:  mirror[r.rd] = mirror[r.rs0] - mirror[r.rs1];
         core_isa_pkg::XOR:  mirror[r.rd] = mirror[r.rs0] ^ mirror[r.rs1];
         core_isa_pkg::AND:  mirror[r.rd] = mirror[r.rs0] & mirror[r.rs1];
         core_isa_pkg::OUT: begin
            outVal = mirror[r.rs0];
            isOut  = 1'b1;
         end
         core_isa_pkg::WAIT: busyLen = int'(m.imm) + 1;
         default: ; // NOP and unused codes
      endcase
      if (r.op inside {core_isa_pkg::ADD, core_isa_pkg::SUB, core_isa_pkg::XOR,
                       core_isa_pkg::AND, core_isa_pkg::OUT}) begin
         busyLen = 2;
      end
   endfunction

   always @(posedge clock) begin
      if (reset) begin
         measuring = 1'b0;
         wasReset  = 1'b1;
      end else begin
         if (wasReset) begin
            checkValue("busy_o after reset", 0, int'(busy_i));
            checkValue("resultValid_o after reset", 0, int'(resultValid_i));
            wasReset = 1'b0;
         end
         if (resultValid_i) begin
            if (!expectOut || outSeen) begin
               reportError("result pulse without a pending OUT");
            end else begin
               checkValue("OUT data", int'(expOut), int'(resultData_i));
               checkValue("OUT pulse cycle", 2, busyCount + 1); // EXEC is cycle 2
               outSeen = 1'b1;
            end
         end
         if (measuring && busy_i) begin
            busyCount++;
         end else if (measuring) begin
            checkValue("busy cycles", expBusy, busyCount);
            if (expectOut && !outSeen) begin
               reportError("OUT finished without a result pulse");
            end
            measuring = 1'b0;
            expectOut = 1'b0;
         end
         if (instrValid_i && !busy_i) begin // acceptance edge
            predict(core_isa_pkg::instrWord_t'(instr_i), expBusy, expOut, expectOut);
            busyCount = 0;
            outSeen   = 1'b0;
            measuring = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/microCoreTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module microCoreTop_tb;

   localparam int LdiCount = 24;
   localparam int AluCount = 48;
   localparam int NumInstr = 16 + 2 * LdiCount + 16 + 2 * AluCount + 12 + 8 + 16;
   localparam int TimeoutCycles = NumInstr * (256 + 2) + 100; // worst WAIT plus idle cycle

   logic                        clock;
   logic                        reset;
   logic                        instrValid;
   logic [`CORE_INSTR_SIZE-1:0] instr;
   logic [3:0]                  testId;
   logic                        busy;
   logic                        resultValid;
   logic [`CORE_DATA_SIZE-1:0]  resultData;
   int                          errorCount;
   int                          checkCount;
   int                          cycleCount;
   integer                      seed;
   logic [31:0]                 rnd;
   logic [`CORE_ADDR_SIZE-1:0]  rd;
   logic [`CORE_ADDR_SIZE-1:0]  rs0;
   logic [`CORE_ADDR_SIZE-1:0]  rs1;
   logic [`CORE_ADDR_SIZE-1:0]  lastRd;

   microCoreTop microCoreTop_inst (
      .clock         (clock),
      .reset         (reset),
      .instrValid_i  (instrValid),
      .instr_i       (instr),
      .busy_o        (busy),
      .resultValid_o (resultValid),
      .resultData_o  (resultData)
   );

   microCoreTop_checker microCoreTop_checker_inst (
      .clock         (clock),
      .reset         (reset),
      .instrValid_i  (instrValid),
      .instr_i       (instr),
      .busy_i        (busy),
      .resultValid_i (resultValid),
      .resultData_i  (resultData),
      .testId_i      (testId),
      .errorCount_o  (errorCount),
      .checkCount_o  (checkCount)
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   initial begin
      cycleCount = 0;
      while (cycleCount < TimeoutCycles) begin
         @(posedge clock);
         cycleCount++;
      end
      $display("ERROR: run timed out after %0d cycles", cycleCount);
      $display("FAIL: see errors above");
      $finish;
   end

   function automatic logic [`CORE_INSTR_SIZE-1:0] regWord(input core_isa_pkg::opcode_t op,
      input logic [`CORE_ADDR_SIZE-1:0] d, input logic [`CORE_ADDR_SIZE-1:0] s0,
      input logic [`CORE_ADDR_SIZE-1:0] s1);
      core_isa_pkg::instrWord_t w;
      w.asReg.op  = op;
      w.asReg.rd  = d;
      w.asReg.rs0 = s0;
      w.asReg.rs1 = s1;
      return w;
   endfunction

   function automatic logic [`CORE_INSTR_SIZE-1:0] immWord(input core_isa_pkg::opcode_t op,
      input logic [`CORE_ADDR_SIZE-1:0] d, input logic [`CORE_DATA_SIZE-1:0] imm);
      core_isa_pkg::instrWord_t w;
      w.asImm.op  = op;
      w.asImm.rd  = d;
      w.asImm.imm = imm;
      return w;
   endfunction

   function automatic core_isa_pkg::opcode_t aluOpcode(input logic [1:0] sel);
      case (sel)
         2'd0:    return core_isa_pkg::ADD;
         2'd1:    return core_isa_pkg::SUB;
         2'd2:    return core_isa_pkg::XOR;
         default: return core_isa_pkg::AND;
      endcase
   endfunction

   // called on a falling edge, returns on the one after acceptance
   task automatic sendInstr(input logic [`CORE_INSTR_SIZE-1:0] word);
      while (busy) begin
         @(negedge clock);
      end
      instrValid = 1'b1;
      instr      = word;
      @(negedge clock);
      instrValid = 1'b0;
   endtask

   task automatic strobeWhileBusy(input logic [`CORE_INSTR_SIZE-1:0] word);
      instrValid = 1'b1;
      instr      = word;
      repeat (2) @(negedge clock);
      instrValid = 1'b0;
   endtask

   initial begin
      seed       = 32'hf7bc_89fe;
      reset      = 1'b1;
      instrValid = 1'b0;
      instr      = '0;
      testId     = 4'd0;
      repeat (2) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      @(negedge clock);

      testId = 4'd1;
      for (int k = 0; k < 16; k++) begin
         sendInstr(regWord(core_isa_pkg::OUT, '0, k[3:0], '0));
      end

      testId = 4'd2;
      for (int k = 0; k < LdiCount; k++) begin
         rnd = $random(seed);
         sendInstr(immWord(core_isa_pkg::LDI, rnd[3:0], rnd[15:8]));
         sendInstr(regWord(core_isa_pkg::OUT, '0, rnd[3:0], '0));
      end

      testId = 4'd3;
      for (int k = 0; k < 16; k++) begin
         rnd = $random(seed);
         sendInstr(immWord(core_isa_pkg::LDI, k[3:0], rnd[7:0]));
      end
      lastRd = '0;
      for (int k = 0; k < AluCount; k++) begin
         rnd = $random(seed);
         rd  = rnd[3:0];
         rs0 = rnd[7:4];
         rs1 = rnd[11:8];
         case (k % 4)
            1:       rd = rs0;
            2:       rd = rs1;
            3:       rs0 = lastRd; // operand from the previous result
            default: ;
         endcase
         sendInstr(regWord(aluOpcode(rnd[13:12]), rd, rs0, rs1));
         sendInstr(regWord(core_isa_pkg::OUT, '0, rd, '0));
         lastRd = rd;
      end

      testId = 4'd4;
      for (int k = 0; k < 6; k++) begin
         rnd = $random(seed);
         sendInstr(immWord(core_isa_pkg::WAIT, '0, (k < 2) ? k[7:0] : rnd[7:0]));
         sendInstr(regWord(core_isa_pkg::OUT, '0, rnd[11:8], '0));
      end

      testId = 4'd5;
      for (int k = 0; k < 4; k++) begin
         rnd = $random(seed);
         sendInstr(immWord(core_isa_pkg::WAIT, '0, 8'd4));
         strobeWhileBusy(immWord(core_isa_pkg::LDI, rnd[3:0], rnd[11:4]));
         sendInstr(regWord(core_isa_pkg::OUT, '0, rnd[3:0], '0));
      end

      testId = 4'd6;
      for (int k = 0; k < 8; k++) begin
         rnd = $random(seed);
         sendInstr({1'b1, rnd[2:0], rnd[15:4]}); // codes 8 to 15
         sendInstr(regWord(core_isa_pkg::OUT, '0, rnd[15:12], '0));
      end

      while (busy) begin
         @(negedge clock);
      end
      repeat (2) @(negedge clock);
      $display("Summary: %0d errors in %0d checks", errorCount, checkCount);
      if (errorCount == 0 && checkCount > 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== microCoreTop.f ====
+incdir+include
source/core_isa_pkg.sv
source/core_ctrl_pkg.sv
source/ramDualPort.sv
source/aluUnit.sv
source/delayTimer.sv
source/instrSequencer.sv
source/microCoreTop.sv
tests/microCoreTop_props.sv
tests/microCoreTop_checker.sv
tests/microCoreTop_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, then scan the log for the verdict
rm -f sim.log
verilator --binary --timing --assert --top-module microCoreTop_tb -f microCoreTop.f \
   && ./obj_dir/VmicroCoreTop_tb > sim.log 2>&1 \
   || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0
